// ==== tileVideoPkg.sv ====
`default_nettype none

package tileVideoPkg;

    parameter int CoordBits   = 10;
    parameter int CodeBits    = 4;
    parameter int ColorBits   = 4;
    parameter int MapAddrBits = 12;
    parameter int RomDataBits = 16;
    parameter int TileSize    = 8; // tile edge in pixels.

    typedef logic [CodeBits-1:0] tileCode_t;

    typedef struct packed {
        logic [3:0] rowTens;
        logic [3:0] rowOnes;
        logic [3:0] col;
    } mapAddr_t; // bcd row digits then the column digit.

    typedef struct packed {
        logic [CoordBits-1:0] x;
        logic [CoordBits-1:0] y;
        logic                 active;
    } scanPos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
    } syncBits_t;

    typedef struct packed {
        logic [ColorBits-1:0] red;
        logic [ColorBits-1:0] green;
        logic [ColorBits-1:0] blue;
    } rgb_t;

    typedef struct packed {
        syncBits_t sync;
        rgb_t      rgb;
    } videoOut_t;

    function automatic rgb_t paletteColor(input tileCode_t code);
        rgb_t color;
        color.red   = {code[ColorBits-2:0], 1'b0}; // twice the code.
        color.green = 4'hF - code;
        color.blue  = code[0] ? 4'hF : 4'h5;
        return color;
    endfunction

endpackage

`default_nettype wire

// ==== videoTiming.sv ====
`timescale 1ns/10ps
`default_nettype none

module videoTiming #(
    parameter int hActive = 80,
    parameter int hFront  = 4,
    parameter int hSync   = 8,
    parameter int hBack   = 8,
    parameter int vActive = 96,
    parameter int vFront  = 2,
    parameter int vSync   = 2,
    parameter int vBack   = 4
) (
    input  logic                   clk,
    input  logic                   rstN,
    output tileVideoPkg::scanPos_t  pos,
    output tileVideoPkg::syncBits_t sync
);

    localparam int hTotal = hActive + hFront + hSync + hBack;
    localparam int vTotal = vActive + vFront + vSync + vBack;
    localparam int hSyncStart = hActive + hFront;
    localparam int vSyncStart = vActive + vFront;

    logic [tileVideoPkg::CoordBits-1:0] xNext;
    logic [tileVideoPkg::CoordBits-1:0] yNext;
    logic                               activeNext;
    logic                               hsyncNext;
    logic                               vsyncNext;

    always_comb begin
        xNext = pos.x;
        yNext = pos.y;
        if (pos.x == tileVideoPkg::CoordBits'(hTotal - 1)) begin
            xNext = '0;
            if (pos.y == tileVideoPkg::CoordBits'(vTotal - 1)) begin
                yNext = '0;
            end else begin
                yNext = pos.y + 1'b1; // new line.
            end
        end else begin
            xNext = pos.x + 1'b1;
        end
    end

    // decode from the next count so flags line up with the registered position
    assign activeNext = (xNext < tileVideoPkg::CoordBits'(hActive))
                     && (yNext < tileVideoPkg::CoordBits'(vActive));
    assign hsyncNext  = (xNext >= tileVideoPkg::CoordBits'(hSyncStart))
                     && (xNext < tileVideoPkg::CoordBits'(hSyncStart + hSync));
    assign vsyncNext  = (yNext >= tileVideoPkg::CoordBits'(vSyncStart))
                     && (yNext < tileVideoPkg::CoordBits'(vSyncStart + vSync));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pos  <= '0;
            sync <= '0;
        end else begin
            pos.x       <= xNext;
            pos.y       <= yNext;
            pos.active  <= activeNext;
            sync.hsync  <= hsyncNext;
            sync.vsync  <= vsyncNext;
            sync.active <= activeNext;
        end
    end

endmodule

`default_nettype wire

// ==== tileAddrGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tileAddrGen (
    input  logic                   clk,
    input  logic                   rstN,
    input  tileVideoPkg::scanPos_t pos,
    output tileVideoPkg::mapAddr_t addr,
    output logic [2:0]             pixRow,
    output logic [2:0]             pixCol
);

    tileVideoPkg::mapAddr_t addrNext;

    always_comb begin
        addrNext = addr;
        if (pos.x == '0) begin
            addrNext.col = '0; // line start.
            if (pos.y == '0) begin
                addrNext.rowTens = '0;
                addrNext.rowOnes = '0;
            end else if (pos.y[2:0] == 3'd0) begin
                if (addr.rowOnes == 4'd9) begin
                    addrNext.rowOnes = '0; // decimal carry.
                    addrNext.rowTens = addr.rowTens + 1'b1;
                end else begin
                    addrNext.rowOnes = addr.rowOnes + 1'b1;
                end
            end
        end else if (pos.x[2:0] == 3'd0) begin
            if (addr.col == 4'd9) begin
                addrNext.col = '0; // only in blanking.
            end else begin
                addrNext.col = addr.col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            addr   <= '0;
            pixRow <= '0;
            pixCol <= '0;
        end else begin
            addr   <= addrNext;
            pixRow <= pos.y[2:0];
            pixCol <= pos.x[2:0];
        end
    end

endmodule

`default_nettype wire

// ==== tileMapRom.sv ====
`timescale 1ns/10ps
`default_nettype none

module tileMapRom #(
    parameter int portSize = 12,
    parameter int dataSize = 16
) (
    input  logic [portSize-1:0] Address,
    output logic [dataSize-1:0] Data
);

    // labels read as {row tens, row ones, col} in bcd
    always_comb begin
        case (Address)
            12'h000: Data = dataSize'(4'h1);
            12'h001: Data = dataSize'(4'h1);
            12'h002: Data = dataSize'(4'h1);
            12'h003: Data = dataSize'(4'h1);
            12'h004: Data = dataSize'(4'h1);
            12'h005: Data = dataSize'(4'h1);
            12'h006: Data = dataSize'(4'h1);
            12'h007: Data = dataSize'(4'h1);
            12'h008: Data = dataSize'(4'h1);
            12'h009: Data = dataSize'(4'h1);
            12'h010: Data = dataSize'(4'h5);
            12'h011: Data = dataSize'(4'h3);
            12'h012: Data = dataSize'(4'h1);
            12'h013: Data = dataSize'(4'h1);
            12'h014: Data = dataSize'(4'h1);
            12'h015: Data = dataSize'(4'h1);
            12'h016: Data = dataSize'(4'h1);
            12'h017: Data = dataSize'(4'h1);
            12'h018: Data = dataSize'(4'h1);
            12'h019: Data = dataSize'(4'h3);
            12'h020: Data = dataSize'(4'h1);
            12'h021: Data = dataSize'(4'h1);
            12'h022: Data = dataSize'(4'h1);
            12'h023: Data = dataSize'(4'h1);
            12'h024: Data = dataSize'(4'h1);
            12'h025: Data = dataSize'(4'h1);
            12'h026: Data = dataSize'(4'h1);
            12'h027: Data = dataSize'(4'h1);
            12'h028: Data = dataSize'(4'h1);
            12'h029: Data = dataSize'(4'h1);
            12'h030: Data = dataSize'(4'h3);
            12'h031: Data = dataSize'(4'h1);
            12'h032: Data = dataSize'(4'h1);
            12'h033: Data = dataSize'(4'h1);
            12'h034: Data = dataSize'(4'h3);
            12'h035: Data = dataSize'(4'h1);
            12'h036: Data = dataSize'(4'h4);
            12'h037: Data = dataSize'(4'h4);
            12'h038: Data = dataSize'(4'h4);
            12'h039: Data = dataSize'(4'h4);
            12'h040: Data = dataSize'(4'h2);
            12'h041: Data = dataSize'(4'h6);
            12'h042: Data = dataSize'(4'h3);
            12'h043: Data = dataSize'(4'h1);
            12'h044: Data = dataSize'(4'h1);
            12'h045: Data = dataSize'(4'h7);
            12'h046: Data = dataSize'(4'h3);
            12'h047: Data = dataSize'(4'h1);
            12'h048: Data = dataSize'(4'h7);
            12'h049: Data = dataSize'(4'h1);
            12'h050: Data = dataSize'(4'h1);
            12'h051: Data = dataSize'(4'h1);
            12'h052: Data = dataSize'(4'h1);
            12'h053: Data = dataSize'(4'h1);
            12'h054: Data = dataSize'(4'h1);
            12'h055: Data = dataSize'(4'h1);
            12'h056: Data = dataSize'(4'h7);
            12'h057: Data = dataSize'(4'h7);
            12'h058: Data = dataSize'(4'h1);
            12'h059: Data = dataSize'(4'h1);
            12'h060: Data = dataSize'(4'h1);
            12'h061: Data = dataSize'(4'h7);
            12'h062: Data = dataSize'(4'h3);
            12'h063: Data = dataSize'(4'h1);
            12'h064: Data = dataSize'(4'h1);
            12'h065: Data = dataSize'(4'h7);
            12'h066: Data = dataSize'(4'h4);
            12'h067: Data = dataSize'(4'h4);
            12'h068: Data = dataSize'(4'h1);
            12'h069: Data = dataSize'(4'h1);
            12'h070: Data = dataSize'(4'h1);
            12'h071: Data = dataSize'(4'h1);
            12'h072: Data = dataSize'(4'h1);
            12'h073: Data = dataSize'(4'h1);
            12'h074: Data = dataSize'(4'h1);
            12'h075: Data = dataSize'(4'h1);
            12'h076: Data = dataSize'(4'h1);
            12'h077: Data = dataSize'(4'h1);
            12'h078: Data = dataSize'(4'h1);
            12'h079: Data = dataSize'(4'h1);
            12'h080: Data = dataSize'(4'h1);
            12'h081: Data = dataSize'(4'h1);
            12'h082: Data = dataSize'(4'h1);
            12'h083: Data = dataSize'(4'h7);
            12'h084: Data = dataSize'(4'h3);
            12'h085: Data = dataSize'(4'h7);
            12'h086: Data = dataSize'(4'h1);
            12'h087: Data = dataSize'(4'h1);
            12'h088: Data = dataSize'(4'h1);
            12'h089: Data = dataSize'(4'h7);
            12'h090: Data = dataSize'(4'h2);
            12'h091: Data = dataSize'(4'h2);
            12'h092: Data = dataSize'(4'h2);
            12'h093: Data = dataSize'(4'h2);
            12'h094: Data = dataSize'(4'h2);
            12'h095: Data = dataSize'(4'h2);
            12'h096: Data = dataSize'(4'h7);
            12'h097: Data = dataSize'(4'h2);
            12'h098: Data = dataSize'(4'h2);
            12'h099: Data = dataSize'(4'h2);
            12'h100: Data = dataSize'(4'h2);
            12'h101: Data = dataSize'(4'h2);
            12'h102: Data = dataSize'(4'h2);
            12'h103: Data = dataSize'(4'h2);
            12'h104: Data = dataSize'(4'h2);
            12'h105: Data = dataSize'(4'h7);
            12'h106: Data = dataSize'(4'h3);
            12'h107: Data = dataSize'(4'h1);
            12'h108: Data = dataSize'(4'h7);
            12'h109: Data = dataSize'(4'h3);
            12'h110: Data = dataSize'(4'h7);
            12'h111: Data = dataSize'(4'h0);
            default: Data = '0; // rest of row 11 and blanking.
        endcase
    end

endmodule

`default_nettype wire

// ==== glyphGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module glyphGen (
    input  logic                    clk,
    input  logic                    rstN,
    input  tileVideoPkg::tileCode_t code,
    input  logic [2:0]              pixRow,
    input  logic [2:0]              pixCol,
    output logic                    pixOn,
    output tileVideoPkg::tileCode_t codeQ
);

    localparam logic [2:0] lastIdx = 3'(tileVideoPkg::TileSize - 1);
    localparam logic [2:0] midLo   = 3'(tileVideoPkg::TileSize / 2 - 1);
    localparam logic [2:0] midHi   = 3'(tileVideoPkg::TileSize / 2);

    logic onEdge;
    logic onMid;
    logic bitNext;

    assign onEdge = (pixRow == 3'd0) || (pixRow == lastIdx)
                 || (pixCol == 3'd0) || (pixCol == lastIdx);
    assign onMid  = (pixRow == midLo) || (pixRow == midHi)
                 || (pixCol == midLo) || (pixCol == midHi);

    always_comb begin
        case (code)
            4'd0: bitNext = 1'b0; // blank.
            4'd1: bitNext = 1'b1; // solid.
            4'd2: bitNext = ~pixRow[0];
            4'd3: bitNext = ~pixCol[0];
            4'd4: bitNext = ~(pixRow[0] ^ pixCol[0]); // checker.
            4'd5: bitNext = onEdge;
            4'd6: bitNext = (pixRow == pixCol);
            4'd7: bitNext = onMid; // cross.
            default: bitNext = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixOn <= 1'b0;
            codeQ <= '0;
        end else begin
            pixOn <= bitNext;
            codeQ <= code; // keeps code aligned with its bit.
        end
    end

endmodule

`default_nettype wire

// ==== pixelOut.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixelOut (
    input  logic                    clk,
    input  logic                    rstN,
    input  tileVideoPkg::syncBits_t sync,
    input  logic                    pixOn,
    input  tileVideoPkg::tileCode_t code,
    output tileVideoPkg::videoOut_t video
);

    // two stages cover the address and glyph registers
    tileVideoPkg::syncBits_t syncDly [2];
    tileVideoPkg::rgb_t      colorNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            syncDly[0] <= '0;
            syncDly[1] <= '0;
        end else begin
            syncDly[0] <= sync;
            syncDly[1] <= syncDly[0];
        end
    end

    always_comb begin
        if (pixOn && syncDly[1].active) begin
            colorNext = tileVideoPkg::paletteColor(code);
        end else begin
            colorNext = '0; // background and blanking.
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            video <= '0;
        end else begin
            video.sync <= syncDly[1];
            video.rgb  <= colorNext;
        end
    end

endmodule

`default_nettype wire

// ==== tileDisplay.sv ====
`timescale 1ns/10ps
`default_nettype none

module tileDisplay #(
    parameter int hActive = 80,
    parameter int hFront  = 4,
    parameter int hSync   = 8,
    parameter int hBack   = 8,
    parameter int vActive = 96,
    parameter int vFront  = 2,
    parameter int vSync   = 2,
    parameter int vBack   = 4
) (
    input  logic                    clk,
    input  logic                    rstN,
    output tileVideoPkg::videoOut_t video
);

    tileVideoPkg::scanPos_t                pos;
    tileVideoPkg::syncBits_t               sync;
    tileVideoPkg::mapAddr_t                addr;
    logic [2:0]                            pixRow;
    logic [2:0]                            pixCol;
    logic [tileVideoPkg::RomDataBits-1:0]  romData;
    logic                                  pixOn;
    tileVideoPkg::tileCode_t               codeQ;

    videoTiming #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) u_timing (.clk(clk), .rstN(rstN), .pos(pos), .sync(sync));

    tileAddrGen u_addr (
        .clk(clk), .rstN(rstN), .pos(pos),
        .addr(addr), .pixRow(pixRow), .pixCol(pixCol)
    );

    tileMapRom #(
        .portSize(tileVideoPkg::MapAddrBits),
        .dataSize(tileVideoPkg::RomDataBits)
    ) u_rom (.Address(addr), .Data(romData));

    glyphGen u_glyph (
        .clk(clk), .rstN(rstN), .code(romData[tileVideoPkg::CodeBits-1:0]),
        .pixRow(pixRow), .pixCol(pixCol), .pixOn(pixOn), .codeQ(codeQ)
    );

    pixelOut u_pixel (
        .clk(clk), .rstN(rstN), .sync(sync),
        .pixOn(pixOn), .code(codeQ), .video(video)
    );

endmodule

`default_nettype wire

// ==== tbTileDisplay.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbTileDisplay;

    localparam int hActive = 80;
    localparam int hFront  = 4;
    localparam int hSync   = 8;
    localparam int hBack   = 8;
    localparam int vActive = 96;
    localparam int vFront  = 2;
    localparam int vSync   = 2;
    localparam int vBack   = 4;

    localparam int hTotal      = hActive + hFront + hSync + hBack;
    localparam int vTotal      = vActive + vFront + vSync + vBack;
    localparam int frameCycles = hTotal * vTotal;
    localparam int resetCycles = 8;
    localparam int mapCols     = 10;
    localparam int mapRows     = 12;

    // one partial frame, two full frames, then the closing vsync edge.
    localparam int timeoutCycles = resetCycles + 3 * frameCycles + frameCycles / 4;

    logic                    clk;
    logic                    rstN;
    tileVideoPkg::videoOut_t video;

    logic [3:0]              tileMap [0:mapRows*mapCols-1];
    tileVideoPkg::rgb_t      firstFrame [0:hActive*vActive-1];

    int mismatchCount = 0;
    int failureCount  = 0;
    int cycleCount    = 0;
    bit runDone       = 1'b0;

    tileVideoPkg::syncBits_t prevSync = '0;
    bit synced        = 1'b0;
    int frameIdx      = 0;
    int scanX         = 0;
    int scanY         = 0;
    int runLength     = 0;
    int lineCount     = 0;
    int hsyncRises    = 0;
    int hsyncWidth    = 0;
    int vsyncWidth    = 0;
    int pixelsChecked = 0;

    tileDisplay #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) u_dut (
        .clk(clk), .rstN(rstN), .video(video)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    // colour a pixel should have, worked out from the map and the glyph table.
    function automatic tileVideoPkg::rgb_t expectedRgb(input int x, input int y);
        tileVideoPkg::rgb_t color;
        int code;
        int r;
        int c;
        bit on;
        color = '0;
        on = 1'b0;
        if (x >= 0 && x < hActive && y >= 0 && y < vActive) begin
            code = tileMap[(y / tileVideoPkg::TileSize) * mapCols + x / tileVideoPkg::TileSize];
            r = y % tileVideoPkg::TileSize;
            c = x % tileVideoPkg::TileSize;
            case (code)
                1: on = 1'b1;
                2: on = (r % 2 == 0);
                3: on = (c % 2 == 0);
                4: on = ((r + c) % 2 == 0);
                5: on = (r == 0 || r == 7 || c == 0 || c == 7);
                6: on = (r == c);
                7: on = (r == 3 || r == 4 || c == 3 || c == 4);
                default: on = 1'b0; // blank and unused codes.
            endcase
            if (on) begin
                color.red   = 4'(code * 2);
                color.green = 4'(15 - code);
                color.blue  = (code % 2 == 1) ? 4'd15 : 4'd5;
            end
        end
        return color;
    endfunction

    task automatic finishRun();
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        $readmemh("tileMapExpect.mem", tileMap);
        if (^tileMap[mapRows*mapCols-1] === 1'bx) begin
            $display("tile map file tileMapExpect.mem could not be read completely");
            failureCount++;
        end
        rstN = 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            compareValue("video during reset", '0, video);
        end
        rstN = 1'b1;
        @(negedge clk);
        compareValue("video after reset", '0, video); // first edge with rstN high.
        wait (runDone);
        compareValue("pixels checked", 2 * hActive * vActive, pixelsChecked);
        finishRun();
    end

    initial begin : watchdog
        while (!runDone && cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        if (!runDone) begin
            $display("timeout: two frames not observed");
            failureCount++;
            finishRun();
        end
    end

    // outputs sampled mid-cycle.
    always @(negedge clk) begin : monitor
        tileVideoPkg::videoOut_t v;
        int pixIdx;
        v = video;
        if (!runDone) begin
            if (!v.sync.active) begin
                compareValue("rgb while blanked", '0, v.rgb);
            end

            if (v.sync.hsync) begin
                hsyncWidth++;
            end
            if (v.sync.hsync && !prevSync.hsync) begin
                hsyncRises++;
            end
            if (!v.sync.hsync && prevSync.hsync) begin
                if (synced) begin
                    compareValue("hsync width", hSync, hsyncWidth);
                end
                hsyncWidth = 0;
            end

            if (v.sync.vsync) begin
                vsyncWidth++;
            end
            if (!v.sync.vsync && prevSync.vsync) begin
                if (synced) begin
                    compareValue("vsync width", vSync * hTotal, vsyncWidth);
                end
                vsyncWidth = 0;
            end
            if (v.sync.vsync && !prevSync.vsync) begin
                if (synced) begin
                    compareValue("active lines per frame", vActive, lineCount);
                    compareValue("hsync pulses per frame", vTotal, hsyncRises);
                end
                synced = 1'b1; // next active line starts a full frame.
                frameIdx++;
                lineCount  = 0;
                hsyncRises = 0;
                scanX = 0;
                scanY = 0;
                if (frameIdx == 3) begin
                    runDone = 1'b1;
                end
            end

            if (v.sync.active) begin
                runLength++;
                if (synced && !runDone) begin
                    compareValue("rgb", expectedRgb(scanX, scanY), v.rgb);
                    if (scanX < hActive && scanY < vActive) begin
                        pixIdx = scanY * hActive + scanX;
                        if (frameIdx == 1) begin
                            firstFrame[pixIdx] = v.rgb;
                        end else begin
                            compareValue("rgb against first frame", firstFrame[pixIdx], v.rgb);
                        end
                    end
                    pixelsChecked++;
                end
                scanX++;
            end else if (prevSync.active) begin
                if (synced) begin
                    compareValue("active run length", hActive, runLength);
                    lineCount++;
                end
                runLength = 0;
                scanY++;
                scanX = 0;
            end

            prevSync = v.sync;
        end
    end

endmodule

`default_nettype wire

// ==== tileMapExpect.mem ====
// tile rows 0 to 11, one per line
// ten hex tile codes per line, columns 0 to 9
1 1 1 1 1 1 1 1 1 1
5 3 1 1 1 1 1 1 1 3
1 1 1 1 1 1 1 1 1 1
3 1 1 1 3 1 4 4 4 4
2 6 3 1 1 7 3 1 7 1
1 1 1 1 1 1 7 7 1 1
1 7 3 1 1 7 4 4 1 1
1 1 1 1 1 1 1 1 1 1
1 1 1 7 3 7 1 1 1 7
2 2 2 2 2 2 7 2 2 2
2 2 2 2 2 7 3 1 7 3
7 0 0 0 0 0 0 0 0 0

// ==== vlog.f ====
tileVideoPkg.sv
videoTiming.sv
tileAddrGen.sv
tileMapRom.sv
glyphGen.sv
pixelOut.sv
tileDisplay.sv
tbTileDisplay.sv
